// ==== source/tiny_core_pkg.sv ====
package tiny_core_pkg;

    localparam int DATA_W = 32;   // Machine word

    typedef logic [3:0] reg_idx_t;
    typedef logic signed [11:0] imm_t;

    // Codes 4, 14 and 15 are reserved and give zero before the addend
    typedef enum logic [3:0] {
        OP_OR   = 4'd0,
        OP_AND  = 4'd1,
        OP_ADD  = 4'd2,
        OP_MUL  = 4'd3,
        OP_SHL  = 4'd5,
        OP_LT   = 4'd6,
        OP_EQ   = 4'd7,
        OP_GT   = 4'd8,
        OP_NAND = 4'd9,
        OP_XOR  = 4'd10,
        OP_SUB  = 4'd11,
        OP_XNOR = 4'd12,
        OP_SHR  = 4'd13
    } opcode_e;

    // Bit 1 set means a memory write, bit 0 picks which side is dereferenced
    typedef enum logic [1:0] {
        REG_FROM_RHS = 2'd0,   // Z <- rhs
        REG_FROM_MEM = 2'd1,   // Z <- [rhs]
        MEM_AT_Z     = 2'd2,   // [Z] <- rhs
        MEM_AT_RHS   = 2'd3    // [rhs] <- Z
    } deref_e;

    typedef struct packed {
        reg_idx_t z;
        reg_idx_t x;
        reg_idx_t y;
        imm_t     imm;
        opcode_e  op;
        deref_e   deref;
        logic     op_type;   // 1 swaps Y and immediate
        logic     valid;
        logic     illegal;
    } decoded_t;

endpackage

// ==== source/mem_port_if.sv ====
interface mem_port_if import tiny_core_pkg::*; #(
    parameter int ADDR_W = 8
);

    logic              req;      // Held until gnt
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              gnt;      // Same cycle as req when this port wins
    logic [DATA_W-1:0] rdata;
    logic              rvalid;   // One cycle after a read grant

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

// ==== source/reg_file.sv ====
module reg_file import tiny_core_pkg::*; #(
    parameter logic [DATA_W-1:0] RESET_VECTOR = '0
) (
    input  logic              clk,
    input  logic              reset_n,
    input  reg_idx_t          i_x_idx,
    input  reg_idx_t          i_y_idx,
    input  reg_idx_t          i_z_idx,
    input  logic              i_z_we,
    input  logic [DATA_W-1:0] i_z_wdata,
    input  logic              i_pc_we,
    input  logic [DATA_W-1:0] i_pc_next,
    output logic [DATA_W-1:0] o_x_val,
    output logic [DATA_W-1:0] o_y_val,
    output logic [DATA_W-1:0] o_z_val,
    output logic [DATA_W-1:0] o_pc
);

    // Entry 15 is the program counter, entry 0 stays zero
    logic [DATA_W-1:0] regs [16];

    assign o_pc    = regs[15];
    assign o_x_val = regs[i_x_idx];
    assign o_y_val = regs[i_y_idx];
    assign o_z_val = regs[i_z_idx];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
            regs[15] <= RESET_VECTOR;
        end else begin
            if (i_pc_we) begin
                regs[15] <= i_pc_next;
            end
            // Later assignment wins, so a jump overrides the increment
            if (i_z_we && i_z_idx != '0) begin
                regs[i_z_idx] <= i_z_wdata;
            end
        end
    end

    // Reads of index 0 rely on the stored zero never changing
    a_r0_stays_zero: assert property (@(posedge clk) disable iff (reset_n)
        (i_z_we && i_z_idx == '0) |=> regs[0] == '0);

endmodule

// ==== source/insn_decode.sv ====
module insn_decode import tiny_core_pkg::*; (
    input  logic [DATA_W-1:0] i_insn,
    output decoded_t          o_dec
);

    // Layout:
    //   31     clear for a normal instruction
    //   30     operand type
    //   29:28  deref mode
    //   27:24  Z, 23:20 X, 19:16 Y
    //   15:12  opcode
    //   11:0   signed immediate
    // Top nibble 1111 is illegal, any other word with bit 31 set is a no-op

    logic [3:0] top_nibble;

    assign top_nibble = i_insn[31:28];

    always_comb begin
        o_dec = '0;   // Fields stay zero unless valid
        if (!i_insn[31]) begin
            o_dec.op_type = i_insn[30];
            o_dec.deref   = deref_e'(i_insn[29:28]);
            o_dec.z       = i_insn[27:24];
            o_dec.x       = i_insn[23:20];
            o_dec.y       = i_insn[19:16];
            o_dec.op      = opcode_e'(i_insn[15:12]);
            o_dec.imm     = i_insn[11:0];
            o_dec.valid   = 1'b1;
        end else if (top_nibble == 4'b1111) begin
            o_dec.illegal = 1'b1;   // Core halts on this one
        end
    end

endmodule

// ==== source/exec_unit.sv ====
module exec_unit import tiny_core_pkg::*; (
    input  decoded_t          i_dec,
    input  logic [DATA_W-1:0] i_x_val,
    input  logic [DATA_W-1:0] i_y_val,
    output logic [DATA_W-1:0] o_rhs
);

    localparam int IMM_W = $bits(imm_t);

    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] operand;
    logic [DATA_W-1:0] addend;
    logic [DATA_W-1:0] result;
    logic              cmp_hit;

    assign imm_ext = {{(DATA_W-IMM_W){i_dec.imm[IMM_W-1]}}, i_dec.imm};

    // Type 0 is X op Y + I, type 1 is X op I + Y
    assign operand = i_dec.op_type ? imm_ext : i_y_val;
    assign addend  = i_dec.op_type ? i_y_val : imm_ext;

    // Compares are signed
    always_comb begin
        case (i_dec.op)
            OP_LT:   cmp_hit = $signed(i_x_val) < $signed(operand);
            OP_EQ:   cmp_hit = i_x_val == operand;
            OP_GT:   cmp_hit = $signed(i_x_val) > $signed(operand);
            default: cmp_hit = 1'b0;
        endcase
    end

    always_comb begin
        case (i_dec.op)
            OP_OR:   result = i_x_val | operand;
            OP_AND:  result = i_x_val & operand;
            OP_ADD:  result = i_x_val + operand;
            OP_MUL:  result = i_x_val * operand;   // Low word only
            OP_SHL:  result = i_x_val << operand;
            OP_LT,
            OP_EQ,
            OP_GT:   result = {DATA_W{cmp_hit}};   // All ones when true
            OP_NAND: result = ~(i_x_val & operand);
            OP_XOR:  result = i_x_val ^ operand;
            OP_SUB:  result = i_x_val - operand;
            OP_XNOR: result = i_x_val ^ ~operand;
            OP_SHR:  result = i_x_val >> operand;  // Logical
            default: result = '0;                  // Reserved codes
        endcase
    end

    assign o_rhs = result + addend;

endmodule

// ==== source/core_ctrl.sv ====
module core_ctrl import tiny_core_pkg::*; #(
    parameter int                ADDR_W       = 8,
    parameter logic [DATA_W-1:0] RESET_VECTOR = '0
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_run,
    mem_port_if.requester     fetch,
    mem_port_if.requester     data,
    output logic              o_halt,
    output logic [DATA_W-1:0] o_pc
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,   // Instruction word arrives here with rvalid
        S_MEM,
        S_LOAD,
        S_WB,
        S_HALT
    } state_e;

    state_e            state;
    logic              halt_q;
    logic [DATA_W-1:0] insn_q;
    logic [DATA_W-1:0] rhs_q;
    logic [DATA_W-1:0] load_q;

    logic [DATA_W-1:0] insn;
    decoded_t          dec;
    logic [DATA_W-1:0] x_val, y_val, z_val;
    logic [DATA_W-1:0] rhs;
    logic [DATA_W-1:0] pc;
    logic              mem_op;
    logic              reg_we;
    logic              pc_we;

    // Decode straight from the bus while the word is arriving
    assign insn = (state == S_EXEC && fetch.rvalid) ? fetch.rdata : insn_q;

    assign mem_op = dec.valid && dec.deref != REG_FROM_RHS;
    assign reg_we = (state == S_WB) && dec.valid && !dec.deref[1];
    assign pc_we  = (state == S_WB) && !dec.illegal;   // PC stays on the illegal word

    assign fetch.req   = (state == S_FETCH) && i_run;
    assign fetch.we    = 1'b0;
    assign fetch.addr  = pc[ADDR_W-1:0];
    assign fetch.wdata = '0;

    assign data.req   = (state == S_MEM);
    assign data.we    = (state == S_MEM) && dec.deref[1];
    assign data.addr  = (dec.deref == MEM_AT_Z) ? z_val[ADDR_W-1:0] : rhs_q[ADDR_W-1:0];
    assign data.wdata = (dec.deref == MEM_AT_Z) ? rhs_q : z_val;

    assign o_halt = halt_q;
    assign o_pc   = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state  <= S_FETCH;
            halt_q <= 1'b0;
        end else begin
            case (state)
                S_FETCH: if (fetch.gnt) state <= S_EXEC;
                S_EXEC: begin
                    if (dec.illegal) begin
                        halt_q <= 1'b1;   // Visible during its writeback
                    end
                    state <= mem_op ? S_MEM : S_WB;
                end
                S_MEM: if (data.gnt) state <= data.we ? S_WB : S_LOAD;
                S_LOAD: if (data.rvalid) state <= S_WB;
                S_WB: state <= halt_q ? S_HALT : S_FETCH;
                default: state <= S_HALT;   // Only reset leaves
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC && fetch.rvalid) begin
            insn_q <= fetch.rdata;
        end
        if (state == S_EXEC) begin
            rhs_q <= rhs;
        end
        if (state == S_LOAD && data.rvalid) begin
            load_q <= data.rdata;
        end
    end

    insn_decode u_insn_decode (
        .i_insn (insn),
        .o_dec  (dec)
    );

    exec_unit u_exec_unit (
        .i_dec   (dec),
        .i_x_val (x_val),
        .i_y_val (y_val),
        .o_rhs   (rhs)
    );

    // Z = 15 with a register write is a jump
    reg_file #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_reg_file (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_x_idx   (dec.x),
        .i_y_idx   (dec.y),
        .i_z_idx   (dec.z),
        .i_z_we    (reg_we),
        .i_z_wdata (dec.deref == REG_FROM_MEM ? load_q : rhs_q),
        .i_pc_we   (pc_we),
        .i_pc_next (pc + DATA_W'(1)),
        .o_x_val   (x_val),
        .o_y_val   (y_val),
        .o_z_val   (z_val),
        .o_pc      (pc)
    );

    a_single_core_req: assert property (@(posedge clk) disable iff (reset_n)
        !(fetch.req && data.req));

endmodule

// ==== source/mem_arbiter.sv ====
module mem_arbiter import tiny_core_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              reset_n,
    mem_port_if.arbiter       data,
    mem_port_if.arbiter       fetch,
    mem_port_if.arbiter       host,
    output logic              o_mem_en,
    output logic              o_mem_we,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic [DATA_W-1:0] o_mem_wdata,
    input  logic [DATA_W-1:0] i_mem_rdata
);

    logic [2:0] gnt_vec;      // {host, fetch, data}
    logic [2:0] rd_owner_q;   // Who gets next cycle's read data

    // Data first, then fetch, host last
    assign data.gnt  = data.req;
    assign fetch.gnt = fetch.req && !data.req;
    assign host.gnt  = host.req && !data.req && !fetch.req;

    assign gnt_vec  = {host.gnt, fetch.gnt, data.gnt};
    assign o_mem_en = |gnt_vec;

    always_comb begin
        o_mem_we    = 1'b0;
        o_mem_addr  = '0;
        o_mem_wdata = '0;
        if (data.gnt) begin
            o_mem_we    = data.we;
            o_mem_addr  = data.addr;
            o_mem_wdata = data.wdata;
        end else if (fetch.gnt) begin
            o_mem_we    = fetch.we;
            o_mem_addr  = fetch.addr;
            o_mem_wdata = fetch.wdata;
        end else if (host.gnt) begin
            o_mem_we    = host.we;
            o_mem_addr  = host.addr;
            o_mem_wdata = host.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            rd_owner_q <= '0;
        end else begin
            rd_owner_q <= gnt_vec & ~{host.we, fetch.we, data.we};   // Reads only
        end
    end

    // Data bus is shared, rvalid tells each port whether it is theirs
    assign data.rdata  = i_mem_rdata;
    assign fetch.rdata = i_mem_rdata;
    assign host.rdata  = i_mem_rdata;

    assign data.rvalid  = rd_owner_q[0];
    assign fetch.rvalid = rd_owner_q[1];
    assign host.rvalid  = rd_owner_q[2];

    a_gnt_onehot: assert property (@(posedge clk) disable iff (reset_n)
        $onehot0(gnt_vec));

endmodule

// ==== source/unified_mem.sv ====
module unified_mem import tiny_core_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              i_en,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_wdata,
    output logic [DATA_W-1:0] o_rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    // Program and data share this array
    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];   // Next cycle
            end
        end
    end

endmodule

// ==== source/tiny_core_top.sv ====
module tiny_core_top import tiny_core_pkg::*; #(
    parameter int                ADDR_W       = 8,
    parameter logic [DATA_W-1:0] RESET_VECTOR = '0
) (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_run,
    input  logic              i_host_req,
    input  logic              i_host_we,
    input  logic [ADDR_W-1:0] i_host_addr,
    input  logic [DATA_W-1:0] i_host_wdata,
    output logic              o_host_gnt,
    output logic [DATA_W-1:0] o_host_rdata,
    output logic              o_host_rvalid,
    output logic              o_halt,
    output logic [DATA_W-1:0] o_pc
);

    logic              mem_en;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;

    mem_port_if #(.ADDR_W(ADDR_W)) data_if ();
    mem_port_if #(.ADDR_W(ADDR_W)) fetch_if ();
    mem_port_if #(.ADDR_W(ADDR_W)) host_if ();

    // Host side of the memory
    assign host_if.req   = i_host_req;
    assign host_if.we    = i_host_we;
    assign host_if.addr  = i_host_addr;
    assign host_if.wdata = i_host_wdata;
    assign o_host_gnt    = host_if.gnt;
    assign o_host_rdata  = host_if.rdata;
    assign o_host_rvalid = host_if.rvalid;

    core_ctrl #(
        .ADDR_W       (ADDR_W),
        .RESET_VECTOR (RESET_VECTOR)
    ) u_core_ctrl (
        .clk     (i_clk),
        .reset_n (i_reset_n),
        .i_run   (i_run),
        .fetch   (fetch_if.requester),
        .data    (data_if.requester),
        .o_halt  (o_halt),
        .o_pc    (o_pc)
    );

    mem_arbiter #(
        .ADDR_W (ADDR_W)
    ) u_mem_arbiter (
        .clk         (i_clk),
        .reset_n     (i_reset_n),
        .data        (data_if.arbiter),
        .fetch       (fetch_if.arbiter),
        .host        (host_if.arbiter),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    unified_mem #(
        .ADDR_W (ADDR_W)
    ) u_unified_mem (
        .clk     (i_clk),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

// ==== testbench/tb_tiny_core.sv ====
module tb_tiny_core import tiny_core_pkg::*; ();

    localparam int                ADDR_W       = 8;
    localparam int                DEPTH        = 1 << ADDR_W;
    localparam logic [DATA_W-1:0] RESET_VECTOR = 32'h0000_0010;
    localparam int                STEP_LIMIT   = 400;
    localparam int                WAIT_LIMIT   = 100;   // Cycles per host handshake
    localparam int                NUM_RANDOM   = 4;
    localparam int                RANDOM_LEN   = 24;

    logic              clk;
    logic              reset_n;
    logic              run;
    logic              host_req;
    logic              host_we;
    logic [ADDR_W-1:0] host_addr;
    logic [DATA_W-1:0] host_wdata;
    logic              host_gnt;
    logic [DATA_W-1:0] host_rdata;
    logic              host_rvalid;
    logic              halt;
    logic [DATA_W-1:0] pc;

    logic [DATA_W-1:0] image     [DEPTH];   // Loaded into the DUT
    logic [DATA_W-1:0] model_mem [DEPTH];
    logic [DATA_W-1:0] dut_mem   [DEPTH];   // Read back after halt
    logic [DATA_W-1:0] lcg_state;
    logic [DATA_W-1:0] exp_pc;
    logic [DATA_W-1:0] halt_pc;
    logic              exp_halted;
    logic              check_busy;
    event              check_ev;

    tiny_core_top #(
        .ADDR_W       (ADDR_W),
        .RESET_VECTOR (RESET_VECTOR)
    ) u_tiny_core_top (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_run         (run),
        .i_host_req    (host_req),
        .i_host_we     (host_we),
        .i_host_addr   (host_addr),
        .i_host_wdata  (host_wdata),
        .o_host_gnt    (host_gnt),
        .o_host_rdata  (host_rdata),
        .o_host_rvalid (host_rvalid),
        .o_halt        (halt),
        .o_pc          (pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic logic [DATA_W-1:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] encode_insn(input logic t, input logic [1:0] deref,
            input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
            input logic [3:0] op, input logic [11:0] imm);
        return {1'b0, t, deref, z, x, y, op, imm};
    endfunction

    // Top nibble F everywhere, so stray fetches halt
    function automatic void fill_image();
        logic [7:0] a;
        for (int i = 0; i < DEPTH; i++) begin
            a = 8'(i);
            image[i] = {4'hF, 4'h0, a, ~a, a ^ 8'h5A};
        end
    endfunction

    function automatic logic [DATA_W-1:0] ref_op(input logic [3:0] op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] ones;
        ones = '1;
        case (op)
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_ADD:  return a + b;
            OP_MUL:  return a * b;
            OP_SHL:  return a << b;
            OP_LT:   return ($signed(a) < $signed(b)) ? ones : '0;
            OP_EQ:   return (a == b) ? ones : '0;
            OP_GT:   return ($signed(a) > $signed(b)) ? ones : '0;
            OP_NAND: return ~(a & b);
            OP_XOR:  return a ^ b;
            OP_SUB:  return a - b;
            OP_XNOR: return ~(a ^ b);
            OP_SHR:  return a >> b;
            default: return '0;   // Reserved codes
        endcase
    endfunction

    // Instruction-set model, one instruction per step
    function automatic void ref_run(input int step_limit, output logic [DATA_W-1:0] fin_pc,
            output logic halted);
        logic [DATA_W-1:0] regs [16];
        logic [DATA_W-1:0] cur_pc;
        logic [DATA_W-1:0] insn;
        logic [DATA_W-1:0] imm_ext;
        logic [DATA_W-1:0] opnd;
        logic [DATA_W-1:0] addend;
        logic [DATA_W-1:0] rhs;
        logic [DATA_W-1:0] wval;
        logic [3:0]        z;
        cur_pc = RESET_VECTOR;
        fin_pc = '0;
        halted = 1'b0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int step = 0; step < step_limit && !halted; step++) begin
            insn = model_mem[cur_pc[ADDR_W-1:0]];
            if (insn[31:28] == 4'hF) begin
                halted = 1'b1;
                fin_pc = cur_pc;   // PC stays on the illegal word
            end else if (insn[31]) begin
                cur_pc = cur_pc + 1;
            end else begin
                regs[15] = cur_pc;
                z = insn[27:24];
                imm_ext = {{(DATA_W - 12){insn[11]}}, insn[11:0]};
                opnd = insn[30] ? imm_ext : regs[insn[19:16]];
                addend = insn[30] ? regs[insn[19:16]] : imm_ext;
                rhs = ref_op(insn[15:12], regs[insn[23:20]], opnd) + addend;
                wval = insn[28] ? model_mem[rhs[ADDR_W-1:0]] : rhs;
                case (insn[29:28])
                    2'd2:    model_mem[regs[z][ADDR_W-1:0]] = rhs;
                    2'd3:    model_mem[rhs[ADDR_W-1:0]] = regs[z];
                    default: ;
                endcase
                cur_pc = cur_pc + 1;
                if (!insn[29] && z == 4'd15) begin
                    cur_pc = wval;   // Jump
                end else if (!insn[29] && z != 4'd0) begin
                    regs[z] = wval;
                end
            end
        end
    endfunction

    function automatic void model_image();
        for (int a = 0; a < DEPTH; a++) begin
            model_mem[a] = image[a];
        end
        ref_run(STEP_LIMIT, exp_pc, exp_halted);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        reset_n  <= 1'b1;
        run      <= 1'b0;
        host_req <= 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;
    endtask

    task automatic wait_host_gnt();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("Timeout: host request was never granted");
            end
        end while (!host_gnt);
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= wdata;
        wait_host_gnt();
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
        int cycles;
        @(posedge clk);
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= addr;
        wait_host_gnt();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("Timeout: host read data never arrived");
            end
        end while (!host_rvalid);
        rdata = host_rdata;
    endtask

    task automatic expect_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] got;
        host_read(addr, got);
        assert (got === exp) else
            stop_on_error($sformatf("[FAIL] o_host_rdata at %02h: got %08h, expected %08h",
                addr, got, exp));
    endtask

    task automatic load_and_start();
        apply_reset();
        for (int a = 0; a < DEPTH; a++) begin
            host_write(ADDR_W'(a), image[a]);
        end
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic finish_program();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > STEP_LIMIT * 6) begin
                stop_on_error("Timeout: core did not halt within the step limit");
            end
        end while (!halt);
        halt_pc = pc;
        repeat (8) @(negedge clk);
        assert (halt) else stop_on_error("o_halt dropped after the core had halted");
        assert (pc === halt_pc) else
            stop_on_error($sformatf("[FAIL] o_pc after halt: got %08h, expected %08h",
                pc, halt_pc));
        for (int a = 0; a < DEPTH; a++) begin
            host_read(ADDR_W'(a), dut_mem[a]);
        end
        check_busy = 1'b1;
        -> check_ev;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("Timeout: comparison of the memory image never finished");
            end
        end while (check_busy);
    endtask

    // Compares the read-back image and halt PC with the model
    initial begin : compare_proc
        forever begin
            @(check_ev);
            assert (halt_pc === exp_pc) else
                stop_on_error($sformatf("[FAIL] o_pc: got %08h, expected %08h", halt_pc, exp_pc));
            for (int a = 0; a < DEPTH; a++) begin
                assert (dut_mem[a] === model_mem[a]) else
                    stop_on_error($sformatf("[FAIL] o_host_rdata at %02h: got %08h, expected %08h",
                        a, dut_mem[a], model_mem[a]));
            end
            check_busy = 1'b0;
        end
    end

    initial begin : main_proc
        logic [DATA_W-1:0] written [16];
        int                base;
        int                n;
        int                tries;
        reset_n    = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lcg_state  = 32'h3c6c;
        check_busy = 1'b0;
        base       = RESET_VECTOR;

        apply_reset();
        @(negedge clk);
        assert (!halt && !host_rvalid && !host_gnt) else
            stop_on_error("Status outputs are not low after reset");
        assert (pc === RESET_VECTOR) else
            stop_on_error($sformatf("[FAIL] o_pc: got %08h, expected %08h", pc, RESET_VECTOR));

        // Plain host writes, then reads
        for (int i = 0; i < 16; i++) begin
            written[i] = next_random();
            host_write(ADDR_W'(64 + i), written[i]);
        end
        for (int i = 0; i < 16; i++) begin
            expect_word(ADDR_W'(64 + i), written[i]);
        end

        // Every opcode and both types stored to 0xA0 and up
        fill_image();
        n = base;
        image[n++] = encode_insn(1'b0, 2'd0, 4'd1, 4'd0, 4'd0, OP_ADD, 12'h7A5);
        image[n++] = encode_insn(1'b1, 2'd0, 4'd1, 4'd1, 4'd1, OP_SHL, 12'd13);
        image[n++] = encode_insn(1'b0, 2'd0, 4'd2, 4'd0, 4'd0, OP_ADD, 12'd3);
        image[n++] = encode_insn(1'b0, 2'd0, 4'd0, 4'd1, 4'd2, OP_XOR, 12'h123);   // r0 write
        for (int op = 0; op < 16; op++) begin
            for (int t = 0; t < 2; t++) begin
                image[n++] = encode_insn(1'(t), 2'd0, 4'd3, 4'd1, 4'd2, 4'(op),
                    (t == 1) ? 12'd5 : 12'hFF9);
                image[n++] = encode_insn(1'b0, 2'd3, 4'd3, 4'd0, 4'd0, OP_ADD,
                    12'(160 + 2 * op + t));
            end
        end
        image[n++] = encode_insn(1'b0, 2'd3, 4'd0, 4'd0, 4'd0, OP_ADD, 12'h0C0);
        image[n] = 32'hF000_0000;
        model_image();
        load_and_start();
        finish_program();

        // Counted loop with loads, both store modes and a jump back through r15
        fill_image();
        image[base + 0]  = encode_insn(1'b0, 2'd1, 4'd1, 4'd0, 4'd0, OP_ADD, 12'h0E0);
        image[base + 1]  = encode_insn(1'b0, 2'd1, 4'd2, 4'd0, 4'd0, OP_ADD, 12'h0E1);
        image[base + 2]  = encode_insn(1'b0, 2'd0, 4'd4, 4'd0, 4'd0, OP_ADD, 12'h0E8);
        image[base + 3]  = encode_insn(1'b0, 2'd0, 4'd3, 4'd3, 4'd2, OP_ADD, 12'h000);
        image[base + 4]  = encode_insn(1'b0, 2'd2, 4'd4, 4'd3, 4'd1, OP_XOR, 12'h000);
        image[base + 5]  = encode_insn(1'b1, 2'd3, 4'd1, 4'd4, 4'd0, OP_ADD, 12'd8);
        image[base + 6]  = encode_insn(1'b1, 2'd0, 4'd4, 4'd4, 4'd0, OP_ADD, 12'd1);
        image[base + 7]  = encode_insn(1'b1, 2'd0, 4'd1, 4'd1, 4'd0, OP_SUB, 12'd1);
        image[base + 8]  = encode_insn(1'b1, 2'd0, 4'd5, 4'd1, 4'd0, OP_GT, 12'd0);
        image[base + 9]  = encode_insn(1'b1, 2'd0, 4'd6, 4'd5, 4'd0, OP_AND, 12'hFF8);
        image[base + 10] = encode_insn(1'b0, 2'd0, 4'd15, 4'd15, 4'd6, OP_ADD, 12'd1);
        image[base + 11] = encode_insn(1'b0, 2'd3, 4'd3, 4'd0, 4'd0, OP_ADD, 12'h0E2);
        image[base + 12] = 32'hF000_0000;
        image[8'hE0] = 32'd5;   // Loop count
        image[8'hE1] = 32'h11;
        model_image();
        load_and_start();
        for (int i = 0; i < 4; i++) begin
            expect_word(ADDR_W'(base + i), image[base + i]);   // Contends with the core
        end
        expect_word(8'hE0, 32'd5);
        finish_program();
        assert (halt_pc === RESET_VECTOR + 12) else
            stop_on_error($sformatf("[FAIL] o_pc: got %08h, expected %08h",
                halt_pc, RESET_VECTOR + 12));

        // Random valid programs redrawn until the model halts
        for (int p = 0; p < NUM_RANDOM; p++) begin
            tries = 0;
            do begin
                tries++;
                if (tries > 20) begin
                    stop_on_error("No halting random program found");
                end
                fill_image();
                for (int k = 0; k < RANDOM_LEN; k++) begin
                    image[base + k] = next_random() & 32'h7FFF_FFFF;
                end
                image[base + RANDOM_LEN] = 32'hF000_0000;
                model_image();
            end while (!exp_halted);
            load_and_start();
            finish_program();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== tiny_core_top.f ====
source/tiny_core_pkg.sv
source/mem_port_if.sv
source/reg_file.sv
source/insn_decode.sv
source/exec_unit.sv
source/core_ctrl.sv
source/mem_arbiter.sv
source/unified_mem.sv
source/tiny_core_top.sv
testbench/tb_tiny_core.sv
